// File: design/corr_pkg.sv
package corr_pkg;

   // ------------------------------
   // Array geometry
   // ------------------------------
   localparam int NUM_ANT    = 24;
   // Antenna pairs served per sample
   localparam int TRATE      = 12;
   localparam int ACCUM_BITS = 12;

   // Plain vector types
   typedef logic [NUM_ANT-1:0]    ant_bits_t;
   typedef logic [4:0]            ant_idx_t;
   typedef logic [3:0]            slot_t;
   typedef logic [ACCUM_BITS-1:0] accum_t;
   typedef logic [15:0]           integ_len_t;
   typedef logic [3:0]            cfg_addr_t;
   typedef logic [15:0]           cfg_data_t;

   // Largest count an accumulator holds
   localparam accum_t ACCUM_MAX = '1;

   // Register map, pair slots sit at 0 to TRATE-1
   localparam cfg_addr_t CFG_ADDR_INTEG = 4'd15;

   // ------------------------------
   // Bundled signals
   // ------------------------------
   // Layout matches the pair write data, a in [4:0] and b in [9:5]
   typedef struct packed {
      ant_idx_t b;
      ant_idx_t a;
   } antenna_pair_t;

   // One sign bit per antenna, real and imaginary
   typedef struct packed {
      ant_bits_t re;
      ant_bits_t im;
   } sample_t;

   typedef struct packed {
      cfg_addr_t addr;
      cfg_data_t data;
   } cfg_write_t;

   // Clear marks the first sweep of a new integration
   typedef struct packed {
      slot_t   slot;
      logic    clear;
      sample_t sample;
   } slot_cmd_t;

   typedef struct packed {
      slot_t  slot;
      accum_t cos;
      accum_t sin;
   } visibility_t;

   // Reset pairing, antenna s against antenna s+12
   localparam antenna_pair_t PAIR_RESET [TRATE] = '{
      '{b: 5'd12, a: 5'd0},
      '{b: 5'd13, a: 5'd1},
      '{b: 5'd14, a: 5'd2},
      '{b: 5'd15, a: 5'd3},
      '{b: 5'd16, a: 5'd4},
      '{b: 5'd17, a: 5'd5},
      '{b: 5'd18, a: 5'd6},
      '{b: 5'd19, a: 5'd7},
      '{b: 5'd20, a: 5'd8},
      '{b: 5'd21, a: 5'd9},
      '{b: 5'd22, a: 5'd10},
      '{b: 5'd23, a: 5'd11}
   };

endpackage

// File: design/corr_config_regs.sv
module corr_config_regs (
   input  logic                    clk_x,
   input  logic                    rst_n,
   input  logic                    cfg_wr,
   input  corr_pkg::cfg_write_t    cfg,
   output corr_pkg::antenna_pair_t pair_table [corr_pkg::TRATE],
   output corr_pkg::integ_len_t    integ_len
);
   import corr_pkg::*;

   logic          pair_wr;
   logic          len_wr;
   antenna_pair_t wr_pair;
   integ_len_t    wr_len;

   // ------------------------------
   // Address decode
   // ------------------------------
   // Pair slots fill the bottom of the map
   assign pair_wr = cfg_wr && (cfg.addr < cfg_addr_t'(TRATE));
   assign len_wr  = cfg_wr && (cfg.addr == CFG_ADDR_INTEG);
   // Anything else falls through untouched

   // Low ten data bits carry b and a
   assign wr_pair = antenna_pair_t'(cfg.data[$bits(antenna_pair_t)-1:0]);

   // Zero length treated as single sample
   assign wr_len = (cfg.data == '0) ? integ_len_t'(1) : integ_len_t'(cfg.data);

   // ------------------------------
   // Pair table
   // ------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         pair_table <= PAIR_RESET;
      end else if (pair_wr) begin
         // One entry per strobe
         pair_table[cfg.addr] <= wr_pair;
      end
   end

   // ------------------------------
   // Integration length
   // ------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         // Dump after every sample until configured
         integ_len <= integ_len_t'(1);
      end else if (len_wr) begin
         integ_len <= wr_len;
      end
   end

   // Antenna indices beyond the array select nothing real
   a_pair_in_range: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      pair_wr |-> (wr_pair.a < NUM_ANT) && (wr_pair.b < NUM_ANT)
   ) else $error("pair write with antenna index out of range");

endmodule

// File: design/corr_sequencer.sv
module corr_sequencer (
   input  logic                 clk_x,
   input  logic                 rst_n,
   input  logic                 sample_vld,
   input  corr_pkg::sample_t    sample,
   input  corr_pkg::integ_len_t integ_len,
   output logic                 cmd_vld,
   output corr_pkg::slot_cmd_t  cmd
);
   import corr_pkg::*;

   typedef enum logic {
      S_IDLE,
      S_SWEEP
   } seq_state_t;

   seq_state_t state;
   slot_t      slot_q;
   logic       clear_q;
   sample_t    sample_q;
   // Samples taken in the running integration
   integ_len_t samp_cnt;
   // Low until the first sample after reset
   logic       primed;
   logic       last_slot;
   logic       integ_done;

   assign last_slot  = (slot_q == slot_t'(TRATE - 1));
   // First sample always starts fresh, RAM contents unknown
   assign integ_done = !primed || (samp_cnt >= integ_len);

   // ------------------------------
   // Sweep FSM and slot counter
   // ------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         slot_q   <= '0;
         clear_q  <= 1'b0;
         samp_cnt <= '0;
         primed   <= 1'b0;
      end else begin
         case (state)
            S_IDLE: if (sample_vld) state <= S_SWEEP;
            // Back-to-back strobe keeps sweeping
            S_SWEEP: if (last_slot && !sample_vld) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase

         if (sample_vld) begin
            slot_q <= '0;
         end else if (state == S_SWEEP && !last_slot) begin
            slot_q <= slot_q + 1'b1;
         end

         // Clear decided once per sample, held for the whole sweep
         if (sample_vld) begin
            primed  <= 1'b1;
            clear_q <= integ_done;
            if (integ_done) begin
               samp_cnt <= integ_len_t'(1);
            end else begin
               samp_cnt <= samp_cnt + 1'b1;
            end
         end
      end
   end

   // Sample capture
   always_ff @(posedge clk_x) begin
      if (sample_vld) sample_q <= sample;
   end

   assign cmd_vld = (state == S_SWEEP);
   assign cmd     = '{slot: slot_q, clear: clear_q, sample: sample_q};

   // Strobe only when idle or on the final slot of a sweep
   a_no_strobe_in_sweep: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      sample_vld |-> (state == S_IDLE) || last_slot
   ) else $error("sample strobe arrived during a sweep");

endmodule

// File: design/correlate_cos_sin.sv
module correlate_cos_sin (
   input  logic             clk_x,
   input  logic             rst_n,
   input  logic             en,
   input  corr_pkg::slot_t  slot,
   input  logic             ar,
   input  logic             br,
   input  logic             bi,
   input  corr_pkg::accum_t dcos,
   input  corr_pkg::accum_t dsin,
   output logic             valid,
   output corr_pkg::slot_t  wslot,
   output corr_pkg::accum_t qcos,
   output corr_pkg::accum_t qsin,
   output logic             overflow_cos,
   output logic             overflow_sin
);
   import corr_pkg::*;

   // Top bit reports a clipped increment
   function automatic logic [ACCUM_BITS:0] sat_inc(accum_t d, logic hit);
      logic [ACCUM_BITS:0] sum;
      sum = {1'b0, d} + {{ACCUM_BITS{1'b0}}, hit};
      if (sum[ACCUM_BITS]) begin
         return {1'b1, ACCUM_MAX};
      end
      return sum;
   endfunction

   logic [ACCUM_BITS:0] cos_next;
   logic [ACCUM_BITS:0] sin_next;

   // Sign agreement, real a against real b
   assign cos_next = sat_inc(dcos, ar == br);
   // Real a against imaginary b
   assign sin_next = sat_inc(dsin, ar == bi);

   // ------------------------------
   // Control and sticky flags
   // ------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         valid        <= 1'b0;
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else begin
         valid <= en;
         // Only reset lowers these again
         if (en) begin
            overflow_cos <= overflow_cos | cos_next[ACCUM_BITS];
            overflow_sin <= overflow_sin | sin_next[ACCUM_BITS];
         end
      end
   end

   // Result stage, written back to the RAM next cycle
   always_ff @(posedge clk_x) begin
      if (en) begin
         wslot <= slot;
         qcos  <= cos_next[ACCUM_BITS-1:0];
         qsin  <= sin_next[ACCUM_BITS-1:0];
      end
   end

endmodule

// File: design/corr_accum_ram.sv
module corr_accum_ram (
   input  logic             clk_x,
   input  logic             we,
   input  corr_pkg::slot_t  waddr,
   input  corr_pkg::accum_t wcos,
   input  corr_pkg::accum_t wsin,
   input  corr_pkg::slot_t  raddr,
   output corr_pkg::accum_t rcos,
   output corr_pkg::accum_t rsin
);
   import corr_pkg::*;

   // One word per time slot
   typedef struct packed {
      accum_t cos;
      accum_t sin;
   } accum_word_t;

   accum_word_t mem [TRATE];
   accum_word_t rd_word;

   // Clocked write port
   always_ff @(posedge clk_x) begin
      if (we) begin
         mem[waddr] <= '{cos: wcos, sin: wsin};
      end
   end

   // Read port is combinational, distributed RAM style
   assign rd_word = mem[raddr];
   assign rcos    = rd_word.cos;
   assign rsin    = rd_word.sin;

endmodule

// File: design/correlator_block.sv
module correlator_block (
   input  logic                    clk_x,
   input  logic                    rst_n,
   input  corr_pkg::antenna_pair_t pair_table [corr_pkg::TRATE],
   input  logic                    cmd_vld,
   input  corr_pkg::slot_cmd_t     cmd,
   output logic                    vis_vld,
   output corr_pkg::visibility_t   vis,
   output logic                    overflow_cos,
   output logic                    overflow_sin
);
   import corr_pkg::*;

   antenna_pair_t pair;
   accum_t        rcos;
   accum_t        rsin;

   // Read stage registers
   logic   go;
   slot_t  go_slot;
   logic   ar;
   logic   br;
   logic   bi;
   accum_t dcos;
   accum_t dsin;

   // Write-back from the correlate unit
   logic   wr_vld;
   slot_t  wr_slot;
   accum_t wcos;
   accum_t wsin;

   // Set once every slot has been written
   logic   holds_data;

   // ------------------------------
   // Pair lookup
   // ------------------------------
   assign pair = pair_table[cmd.slot];

   corr_accum_ram i_accum_ram (
      .clk_x (clk_x),
      .we    (wr_vld),
      .waddr (wr_slot),
      .wcos  (wcos),
      .wsin  (wsin),
      .raddr (cmd.slot),
      .rcos  (rcos),
      .rsin  (rsin)
   );

   // ------------------------------
   // Read stage
   // ------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         go         <= 1'b0;
         vis_vld    <= 1'b0;
         holds_data <= 1'b0;
      end else begin
         go <= cmd_vld;
         // Dump finished counts on the switch sweep
         vis_vld <= cmd_vld && cmd.clear && holds_data;
         if (cmd_vld && cmd.slot == slot_t'(TRATE - 1)) begin
            holds_data <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_x) begin
      if (cmd_vld) begin
         go_slot <= cmd.slot;
         ar      <= cmd.sample.re[pair.a];
         br      <= cmd.sample.re[pair.b];
         bi      <= cmd.sample.im[pair.b];
         // Zero input restarts the integration
         dcos    <= cmd.clear ? '0 : rcos;
         dsin    <= cmd.clear ? '0 : rsin;
         // Old word leaves as the visibility
         vis     <= '{slot: cmd.slot, cos: rcos, sin: rsin};
      end
   end

   correlate_cos_sin i_correlate (
      .clk_x        (clk_x),
      .rst_n        (rst_n),
      .en           (go),
      .slot         (go_slot),
      .ar           (ar),
      .br           (br),
      .bi           (bi),
      .dcos         (dcos),
      .dsin         (dsin),
      .valid        (wr_vld),
      .wslot        (wr_slot),
      .qcos         (wcos),
      .qsin         (wsin),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   // Write-back two cycles late, must never hit the slot being read
   a_no_rw_collision: assert property (
      @(posedge clk_x) disable iff (!rst_n)
      cmd_vld && wr_vld |-> cmd.slot != wr_slot
   ) else $error("accumulator read and write on the same slot");

endmodule

// File: design/corr_top.sv
module corr_top (
   input  logic                  clk_x,
   input  logic                  rst_n,
   input  logic                  cfg_wr,
   input  corr_pkg::cfg_write_t  cfg,
   input  logic                  sample_vld,
   input  corr_pkg::sample_t     sample,
   output logic                  vis_vld,
   output corr_pkg::visibility_t vis,
   output logic                  overflow_cos,
   output logic                  overflow_sin
);
   import corr_pkg::*;

   antenna_pair_t pair_table [TRATE];
   integ_len_t    integ_len;
   logic          cmd_vld;
   slot_cmd_t     cmd;

   // Settings beside the datapath
   corr_config_regs i_config_regs (
      .clk_x      (clk_x),
      .rst_n      (rst_n),
      .cfg_wr     (cfg_wr),
      .cfg        (cfg),
      .pair_table (pair_table),
      .integ_len  (integ_len)
   );

   corr_sequencer i_sequencer (
      .clk_x      (clk_x),
      .rst_n      (rst_n),
      .sample_vld (sample_vld),
      .sample     (sample),
      .integ_len  (integ_len),
      .cmd_vld    (cmd_vld),
      .cmd        (cmd)
   );

   correlator_block i_correlator (
      .clk_x        (clk_x),
      .rst_n        (rst_n),
      .pair_table   (pair_table),
      .cmd_vld      (cmd_vld),
      .cmd          (cmd),
      .vis_vld      (vis_vld),
      .vis          (vis),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
   output logic clk_x,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   // 8 ns period
   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 5;

   initial begin
      clk_x = 1'b0;
      forever #HALF_PERIOD clk_x = ~clk_x;
   end

   // Release just after an edge, clear of the sampling point
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_x);
      #1 rst_n = 1'b1;
   end

endmodule

// File: testbench/tb_corr_top.sv
module tb_corr_top;
   timeunit 1ns;
   timeprecision 100ps;
   import corr_pkg::*;

   localparam int        DRIVE_DLY       = 1;
   // One sweep plus pipeline drain per sample
   localparam int        SAMPLE_GAP      = TRATE + 4;
   localparam int        WATCHDOG_MARGIN = 1000;
   // Equal upper and lower halves make s and s+12 agree
   localparam ant_bits_t CONST_RE        = 24'h5A35A3;
   localparam cfg_addr_t UNUSED_ADDR     = 4'd13;

   // No override keeps whatever table the DUT holds
   typedef enum logic [1:0] {SEL_NONE, SEL_RESET, SEL_CROSS, SEL_SELF} pair_sel_t;
   typedef enum logic [1:0] {MODE_RANDOM, MODE_CONST, MODE_ALT} sample_mode_t;

   typedef struct packed {
      pair_sel_t    pairs;
      integ_len_t   len;
      logic [15:0]  n_samples;
      sample_mode_t mode;
   } test_row_t;

   // ------------------------------
   // Stimulus table
   // ------------------------------
   // Each row ends on an integration boundary and lengths never grow
   localparam int NUM_TESTS = 6;
   localparam test_row_t TESTS [NUM_TESTS] = '{
      '{pairs: SEL_NONE,  len: 16'd4100, n_samples: 16'd4100, mode: MODE_CONST},
      '{pairs: SEL_NONE,  len: 16'd9,    n_samples: 16'd18,   mode: MODE_RANDOM},
      '{pairs: SEL_NONE,  len: 16'd5,    n_samples: 16'd15,   mode: MODE_RANDOM},
      '{pairs: SEL_CROSS, len: 16'd4,    n_samples: 16'd8,    mode: MODE_CONST},
      '{pairs: SEL_SELF,  len: 16'd3,    n_samples: 16'd6,    mode: MODE_ALT},
      '{pairs: SEL_RESET, len: 16'd1,    n_samples: 16'd6,    mode: MODE_RANDOM}
   };

   logic        clk_x;
   logic        rst_n;
   logic        cfg_wr;
   cfg_write_t  cfg;
   logic        sample_vld;
   sample_t     sample;
   logic        vis_vld;
   visibility_t vis;
   logic        overflow_cos;
   logic        overflow_sin;

   // Reference model state
   antenna_pair_t model_pairs [TRATE];
   accum_t        acc_cos [TRATE];
   accum_t        acc_sin [TRATE];
   int            model_len;
   int            model_cnt;
   logic          model_primed;
   logic          model_ovf_cos;
   logic          model_ovf_sin;
   visibility_t   expected_q [$];

   int seed       = 31;
   int err_cnt    = 0;
   int cyc        = 0;
   int strobe_cyc = 0;
   int vis_seen   = 0;
   int vis_total  = 0;

   tb_clock_gen i_clock_gen (
      .clk_x (clk_x),
      .rst_n (rst_n)
   );

   corr_top i_dut (
      .clk_x        (clk_x),
      .rst_n        (rst_n),
      .cfg_wr       (cfg_wr),
      .cfg          (cfg),
      .sample_vld   (sample_vld),
      .sample       (sample),
      .vis_vld      (vis_vld),
      .vis          (vis),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic fail_run(string reason);
      err_cnt++;
      $display("Done: errors found");
      $fatal(1, "%s", reason);
   endtask

   // Values shown as slot/cos/sin
   task automatic check_vis(visibility_t got, visibility_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: vis got %0d/%0d/%0d expected %0d/%0d/%0d",
                  $time, got.slot, got.cos, got.sin, exp.slot, exp.cos, exp.sin);
         fail_run("visibility mismatch");
      end
   endtask

   task automatic check_flag(logic got, logic exp, string name);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
         fail_run("flag mismatch");
      end
   endtask

   task automatic check_delay(int got, int exp, string name);
      if (got != exp) begin
         $display("CHECK FAILED at %0t: %s got %0d expected %0d cycles", $time, name, got, exp);
         fail_run("timing mismatch");
      end
   endtask

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic antenna_pair_t pick_pair(pair_sel_t sel, int s);
      antenna_pair_t p;
      case (sel)
         SEL_CROSS: begin
            p.a = ant_idx_t'(s);
            p.b = ant_idx_t'(NUM_ANT - 1 - s);
         end
         // Even antennas against themselves
         SEL_SELF: begin
            p.a = ant_idx_t'(2 * s);
            p.b = ant_idx_t'(2 * s);
         end
         default: begin
            p.a = ant_idx_t'(s);
            p.b = ant_idx_t'(s + TRATE);
         end
      endcase
      return p;
   endfunction

   // Saturating count with sticky flag
   task automatic bump_count(inout accum_t acc, inout logic ovf);
      if (acc == {ACCUM_BITS{1'b1}}) begin
         ovf = 1'b1;
      end else begin
         acc = acc + 1'b1;
      end
   endtask

   task automatic model_sample(sample_t smp);
      antenna_pair_t p;
      visibility_t   v;
      // New integration on the first sample or once the length is reached
      if (!model_primed || model_cnt >= model_len) begin
         if (model_primed) begin
            for (int i = 0; i < TRATE; i++) begin
               v.slot = slot_t'(i);
               v.cos  = acc_cos[i];
               v.sin  = acc_sin[i];
               expected_q.push_back(v);
               vis_total++;
            end
         end
         for (int i = 0; i < TRATE; i++) begin
            acc_cos[i] = '0;
            acc_sin[i] = '0;
         end
         model_cnt = 0;
      end
      model_primed = 1'b1;
      model_cnt++;
      for (int i = 0; i < TRATE; i++) begin
         p = model_pairs[i];
         if (smp.re[p.a] == smp.re[p.b]) bump_count(acc_cos[i], model_ovf_cos);
         if (smp.re[p.a] == smp.im[p.b]) bump_count(acc_sin[i], model_ovf_sin);
      end
   endtask

   function automatic sample_t make_sample(sample_mode_t mode, int k);
      sample_t smp;
      case (mode)
         MODE_RANDOM: begin
            smp.re = ant_bits_t'($random(seed));
            smp.im = ant_bits_t'($random(seed));
         end
         // Imaginary bits follow re on even samples only
         MODE_ALT: begin
            smp.re = CONST_RE;
            smp.im = k[0] ? ~CONST_RE : CONST_RE;
         end
         default: begin
            smp.re = CONST_RE;
            smp.im = ~CONST_RE;
         end
      endcase
      return smp;
   endfunction

   function automatic int total_samples();
      int n;
      n = 0;
      for (int t = 0; t < NUM_TESTS; t++) n += int'(TESTS[t].n_samples);
      return n;
   endfunction

   // ------------------------------
   // Drivers
   // ------------------------------
   task automatic cfg_write(cfg_addr_t addr, cfg_data_t data);
      @(posedge clk_x);
      #DRIVE_DLY;
      cfg_wr    = 1'b1;
      cfg.addr  = addr;
      cfg.data  = data;
      @(posedge clk_x);
      #DRIVE_DLY;
      cfg_wr    = 1'b0;
      // Register map as seen by the model
      if (addr < TRATE) begin
         model_pairs[addr].a = data[4:0];
         model_pairs[addr].b = data[9:5];
      end else if (addr == CFG_ADDR_INTEG) begin
         model_len = (data == '0) ? 1 : int'(data);
      end
   endtask

   task automatic load_pairs(pair_sel_t sel);
      antenna_pair_t p;
      for (int s = 0; s < TRATE; s++) begin
         p = pick_pair(sel, s);
         cfg_write(cfg_addr_t'(s), {6'b0, p.b, p.a});
      end
   endtask

   task automatic send_sample(sample_t smp);
      @(posedge clk_x);
      #DRIVE_DLY;
      sample_vld = 1'b1;
      sample     = smp;
      model_sample(smp);
      @(posedge clk_x);
      #DRIVE_DLY;
      sample_vld = 1'b0;
      // Sweep and write-back settle inside the gap
      repeat (SAMPLE_GAP - 2) @(posedge clk_x);
      #DRIVE_DLY;
      check_flag(overflow_cos, model_ovf_cos, "overflow_cos");
      check_flag(overflow_sin, model_ovf_sin, "overflow_sin");
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin : stimulus
      cfg_wr        = 1'b0;
      cfg           = '0;
      sample_vld    = 1'b0;
      sample        = '0;
      model_len     = 1;
      model_cnt     = 0;
      model_primed  = 1'b0;
      model_ovf_cos = 1'b0;
      model_ovf_sin = 1'b0;
      for (int i = 0; i < TRATE; i++) begin
         model_pairs[i] = pick_pair(SEL_RESET, i);
         acc_cos[i]     = '0;
         acc_sin[i]     = '0;
      end

      @(posedge rst_n);
      @(posedge clk_x);
      #DRIVE_DLY;
      // Flags start low out of reset
      check_flag(overflow_cos, 1'b0, "overflow_cos");
      check_flag(overflow_sin, 1'b0, "overflow_sin");

      for (int t = 0; t < NUM_TESTS; t++) begin
         $display("Row %0d: len %0d, %0d samples", t, TESTS[t].len, TESTS[t].n_samples);
         if (TESTS[t].pairs != SEL_NONE) begin
            load_pairs(TESTS[t].pairs);
         end
         cfg_write(CFG_ADDR_INTEG, cfg_data_t'(TESTS[t].len));
         // Unmapped address changes neither pairs nor length
         cfg_write(UNUSED_ADDR, 16'h03FF);
         for (int k = 0; k < TESTS[t].n_samples; k++) begin
            send_sample(make_sample(TESTS[t].mode, k));
         end
      end

      // Extra sample dumps the last integration
      send_sample(make_sample(MODE_CONST, 0));
      repeat (2 * SAMPLE_GAP) @(posedge clk_x);

      if (expected_q.size() != 0 || vis_seen != vis_total) begin
         $display("ERROR: only %0d of %0d visibilities arrived", vis_seen, vis_total);
         err_cnt++;
      end
      if (err_cnt == 0) begin
         $display("%0d visibilities checked", vis_seen);
         $display("Done: no errors");
         $finish;
      end else begin
         fail_run("visibilities missing at end of run");
      end
   end

   // ------------------------------
   // Output monitor
   // ------------------------------
   // Sampled on the falling edge between drive and capture
   initial begin : monitor
      visibility_t exp_vis;
      forever begin
         @(negedge clk_x);
         cyc++;
         if (rst_n) begin
            if (sample_vld) strobe_cyc = cyc;
            if (vis_vld) begin
               if (expected_q.size() == 0) begin
                  $display("ERROR: vis_vld high at %0t with no finished integration", $time);
                  fail_run("unexpected visibility");
               end else begin
                  exp_vis = expected_q.pop_front();
                  check_vis(vis, exp_vis);
                  // Slot s lands s+2 cycles after its strobe
                  check_delay(cyc - strobe_cyc, int'(exp_vis.slot) + 2, "vis_vld delay");
                  vis_seen++;
               end
            end
         end
      end
   end

   // Bound from table length
   initial begin : watchdog
      int limit;
      limit = (total_samples() + 1) * SAMPLE_GAP + WATCHDOG_MARGIN;
      repeat (limit) @(posedge clk_x);
      $display("ERROR: run did not finish within %0d cycles", limit);
      fail_run("watchdog timeout");
   end

endmodule

// File: files.f
design/corr_pkg.sv
design/corr_config_regs.sv
design/corr_sequencer.sv
design/correlate_cos_sin.sv
design/corr_accum_ram.sv
design/correlator_block.sv
design/corr_top.sv
testbench/tb_clock_gen.sv
testbench/tb_corr_top.sv

// File: Bender.yml
package:
  name: corr_correlator

sources:
  - design/corr_pkg.sv
  - design/corr_config_regs.sv
  - design/corr_sequencer.sv
  - design/correlate_cos_sin.sv
  - design/corr_accum_ram.sv
  - design/correlator_block.sv
  - design/corr_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_corr_top.sv
